// File: realtime_settings.svh
/* build-time parameters of the sample path
   sample width, samples per beat, channel count, capture depth */

`ifndef REALTIME_SETTINGS_SVH
`define REALTIME_SETTINGS_SVH

// bits per signed sample
`define SAMPLE_WIDTH 16

// samples delivered per channel on each beat, element 0 oldest
`define PARALLEL_SAMPLES 2

// independent channels on the bus
`define CHANNELS 4

// beats stored per channel between start and stop
`define BUFFER_DEPTH 32

`endif

// File: realtime_pkg.sv
/* shared types: sample, channel beat, multichannel bus,
   readout header, readout word union and readout beat */

`default_nettype none
`include "realtime_settings.svh"

package realtime_pkg;

  localparam int BEAT_WIDTH = `SAMPLE_WIDTH * `PARALLEL_SAMPLES;
  localparam int CHANNEL_BITS = (`CHANNELS > 1) ? $clog2(`CHANNELS) : 1;
  localparam int HEADER_PAD = BEAT_WIDTH - 24; // header uses 8 + 16 bits

  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

  // element 0 is the oldest sample of the beat
  typedef sample_t [`PARALLEL_SAMPLES-1:0] channel_beat_t;

  // wide enough to hold BUFFER_DEPTH itself
  typedef logic [$clog2(`BUFFER_DEPTH+1)-1:0] count_t;

  typedef struct packed {
    logic [`CHANNELS-1:0]          valid; // one strobe per channel
    channel_beat_t [`CHANNELS-1:0] data;
  } realtime_bus_t;

  typedef struct packed {
    logic [HEADER_PAD-1:0] pad;     // always zero
    logic [7:0]            channel;
    logic [15:0]           count;   // stored words that follow
  } readout_header_t;

  // a readout word is either a header or one stored beat
  typedef union packed {
    channel_beat_t   samples;
    readout_header_t header;
  } readout_word_u;

  typedef struct packed {
    logic          valid;
    logic          header; // word holds the header view
    logic          last;   // final beat of the final channel
    readout_word_u word;
  } readout_beat_t;

endpackage

`default_nettype wire

// File: realtime_differentiator.sv
/* multichannel first-order differentiator
   difference against the previous sample, halved by truncation */

`default_nettype none
`include "realtime_settings.svh"

module realtime_differentiator import realtime_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  realtime_bus_t in_bus,
  output realtime_bus_t out_bus
);

  // every stage of a channel moves only when that channel's valid is high
  channel_beat_t [`CHANNELS-1:0] in_reg;     // stage 1, accepted beat
  sample_t [`CHANNELS-1:0]       prev_last;  // last sample of the beat before in_reg
  channel_beat_t [`CHANNELS-1:0] pred;       // predecessor of each sample in in_reg
  logic [`CHANNELS-1:0][`PARALLEL_SAMPLES-1:0][`SAMPLE_WIDTH:0] diff_full; // stage 2
  channel_beat_t [`CHANNELS-1:0] diff_half;  // stage 3
  channel_beat_t [`CHANNELS-1:0] out_data;   // stage 4
  logic [`CHANNELS-1:0][2:0]     valid_hist; // fill level of the pipeline
  logic [`CHANNELS-1:0]          out_valid;

  // sample 0 reaches back into the previous beat, the rest look one slot down
  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      pred[ch][0] = prev_last[ch];
      for (int s = 1; s < `PARALLEL_SAMPLES; s++) begin
        pred[ch][s] = in_reg[ch][s-1];
      end
    end
  end

  // control and input stage; prev_last has to start at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      in_reg     <= '0;
      prev_last  <= '0;
      valid_hist <= '0;
      out_valid  <= '0;
    end else begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        out_valid[ch] <= in_bus.valid[ch] & valid_hist[ch][2]; // pulse per accepted beat
        if (in_bus.valid[ch]) begin
          in_reg[ch]     <= in_bus.data[ch];
          prev_last[ch]  <= in_reg[ch][`PARALLEL_SAMPLES-1];
          valid_hist[ch] <= {valid_hist[ch][1:0], 1'b1};
        end
      end
    end
  end

  // arithmetic stages
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      if (in_bus.valid[ch]) begin
        for (int s = 0; s < `PARALLEL_SAMPLES; s++) begin
          // sign extend both operands so the difference never wraps
          diff_full[ch][s] <= {in_reg[ch][s][`SAMPLE_WIDTH-1], in_reg[ch][s]}
                            - {pred[ch][s][`SAMPLE_WIDTH-1], pred[ch][s]};
          diff_half[ch][s] <= diff_full[ch][s][`SAMPLE_WIDTH:1]; // floor of diff / 2
        end
        out_data[ch] <= diff_half[ch];
      end
    end
  end

  assign out_bus.valid = out_valid;
  assign out_bus.data  = out_data;

endmodule

`default_nettype wire

// File: sample_capture_buffer.sv
/* per-channel capture memory for differentiated beats
   start and stop control, saturating word counts, registered read port */

`default_nettype none
`include "realtime_settings.svh"

module sample_capture_buffer import realtime_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    capture_start,
  input  logic                    capture_stop,
  input  logic                    readout_busy,
  input  realtime_bus_t           diff_bus,
  input  logic                    rd_en,
  input  logic [CHANNEL_BITS-1:0] rd_channel,
  input  count_t                  rd_addr,
  output channel_beat_t           rd_data,
  output count_t [`CHANNELS-1:0]  word_count,
  output logic                    capturing
);

  localparam int ADDR_BITS = $clog2(`BUFFER_DEPTH);

  // one region of BUFFER_DEPTH beats per channel
  channel_beat_t mem [`CHANNELS][`BUFFER_DEPTH];

  logic [`CHANNELS-1:0] full;   // region has no free slot left
  logic [`CHANNELS-1:0] wr_en;  // store this cycle's beat
  logic                 start_ok;

  // a start pulse during readout would wipe the counts being read
  assign start_ok = capture_start & ~readout_busy;

  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      full[ch] = (word_count[ch] >= count_t'(`BUFFER_DEPTH));
      // capturing is the registered window, so the stop cycle still stores
      wr_en[ch] = capturing & ~readout_busy & diff_bus.valid[ch] & ~full[ch];
    end
  end

  // capture window
  always_ff @(posedge clk) begin
    if (reset) begin
      capturing <= 1'b0;
    end else if (start_ok) begin
      capturing <= 1'b1;
    end else if (capture_stop) begin
      capturing <= 1'b0;
    end
  end

  // write pointer per channel, doubles as its word count
  always_ff @(posedge clk) begin
    if (reset) begin
      word_count <= '0;
    end else if (start_ok) begin
      word_count <= '0; // fresh capture, old contents are dropped
    end else begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        if (wr_en[ch]) begin
          word_count[ch] <= word_count[ch] + count_t'(1); // stops at BUFFER_DEPTH
        end
      end
    end
  end

  // storage writes, one port per channel region
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      if (wr_en[ch]) begin
        mem[ch][word_count[ch][ADDR_BITS-1:0]] <= diff_bus.data[ch];
      end
    end
  end

  // single read port, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_channel][rd_addr[ADDR_BITS-1:0]];
    end
  end

endmodule

`default_nettype wire

// File: buffer_readout.sv
/* readout sequencer for the capture buffer
   walks the channels in order, emitting a header and then the stored beats */

`default_nettype none
`include "realtime_settings.svh"

module buffer_readout import realtime_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    readout_start,
  input  count_t [`CHANNELS-1:0]  word_count,
  input  channel_beat_t           rd_data,
  output logic                    rd_en,
  output logic [CHANNEL_BITS-1:0] rd_channel,
  output count_t                  rd_addr,
  output logic                    readout_busy,
  output readout_beat_t           readout
);

  typedef enum logic [1:0] {IDLE, HEADER, DATA} state_t;

  state_t                  state;
  logic [CHANNEL_BITS-1:0] chan;      // channel being read out
  count_t                  addr;      // next word within the channel
  count_t [`CHANNELS-1:0]  counts;    // snapshot taken at readout_start
  count_t                  cur_count;
  logic                    final_chan;
  logic                    chan_done; // this issue slot ends the channel

  // one cycle behind the issue slot, lined up with rd_data
  logic                    d_valid;
  logic                    d_header;
  logic                    d_last;
  logic [CHANNEL_BITS-1:0] d_channel;
  count_t                  d_count;

  assign cur_count  = counts[chan];
  assign final_chan = (chan == CHANNEL_BITS'(`CHANNELS - 1));
  assign chan_done  = ((state == HEADER) && (cur_count == '0))
                    | ((state == DATA) && (addr == cur_count - count_t'(1)));

  assign rd_en        = (state == DATA);
  assign rd_channel   = chan;
  assign rd_addr      = addr;
  assign readout_busy = (state != IDLE) | d_valid; // held until the last beat leaves

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      chan  <= '0;
      addr  <= '0;
    end else begin
      case (state)
        IDLE: if (readout_start) begin
          counts <= word_count;
          chan   <= '0;
          state  <= HEADER;
        end
        HEADER, DATA: begin
          addr <= (state == HEADER) ? '0 : addr + count_t'(1);
          if (chan_done) begin
            chan  <= chan + 1'b1;
            state <= final_chan ? IDLE : HEADER;
          end else begin
            state <= DATA;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid  <= 1'b0;
      d_header <= 1'b0;
      d_last   <= 1'b0;
    end else begin
      d_valid  <= (state != IDLE);
      d_header <= (state == HEADER);
      d_last   <= chan_done & final_chan;
    end
    d_channel <= chan;
    d_count   <= cur_count;
  end

  // header view built locally, sample view straight from the buffer
  always_comb begin
    readout        = '0;
    readout.valid  = d_valid;
    readout.header = d_header;
    readout.last   = d_last;
    if (d_header) begin
      readout.word.header.pad     = '0;
      readout.word.header.channel = 8'(d_channel);
      readout.word.header.count   = 16'(d_count);
    end else begin
      readout.word.samples = rd_data;
    end
  end

endmodule

`default_nettype wire

// File: differentiator_capture_top.sv
/* top level of the sample path
   differentiator into capture buffer, buffer read out by the sequencer */

`default_nettype none
`include "realtime_settings.svh"

module differentiator_capture_top import realtime_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          capture_start,
  input  logic          capture_stop,
  input  logic          readout_start,
  input  realtime_bus_t in_bus,
  output realtime_bus_t diff_bus,       // differentiator output, also observable
  output logic          capturing,
  output logic          readout_busy,
  output readout_beat_t readout
);

  // buffer read port
  logic                    rd_en;
  logic [CHANNEL_BITS-1:0] rd_channel;
  count_t                  rd_addr;
  channel_beat_t           rd_data;
  count_t [`CHANNELS-1:0]  word_count;

  realtime_differentiator realtime_differentiator_i (
    .clk     (clk),
    .reset   (reset),
    .in_bus  (in_bus),
    .out_bus (diff_bus)
  );

  sample_capture_buffer sample_capture_buffer_i (
    .clk           (clk),
    .reset         (reset),
    .capture_start (capture_start),
    .capture_stop  (capture_stop),
    .readout_busy  (readout_busy),  // blocks start and writes during readout
    .diff_bus      (diff_bus),
    .rd_en         (rd_en),
    .rd_channel    (rd_channel),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .word_count    (word_count),
    .capturing     (capturing)
  );

  buffer_readout buffer_readout_i (
    .clk           (clk),
    .reset         (reset),
    .readout_start (readout_start),
    .word_count    (word_count),
    .rd_data       (rd_data),
    .rd_en         (rd_en),
    .rd_channel    (rd_channel),
    .rd_addr       (rd_addr),
    .readout_busy  (readout_busy),
    .readout       (readout)
  );

endmodule

`default_nettype wire

// File: tb_differentiator_capture.sv
/* testbench for the differentiator and capture path
   random stimulus, reference model, assertions and watchdog */

`default_nettype none
`include "realtime_settings.svh"

module tb_differentiator_capture import realtime_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int IDLE_CYCLES     = 10;
  localparam int STREAM_CYCLES   = 200;
  localparam int WINDOW_CYCLES   = 30;
  localparam int SATURATE_CYCLES = 90;
  localparam int SHORT_CYCLES    = 10;
  localparam int READOUT_CYCLES  = `CHANNELS * (`BUFFER_DEPTH + 1) + 4; // worst case walk
  // five readouts, four short streams and a few single control cycles
  localparam int RUN_CYCLES      = RESET_CYCLES + IDLE_CYCLES + STREAM_CYCLES + WINDOW_CYCLES
                                 + SATURATE_CYCLES + 4 * SHORT_CYCLES
                                 + 5 * (READOUT_CYCLES + 1) + 10;
  localparam int WATCHDOG_TIME   = (RUN_CYCLES + 100) * CLK_PERIOD;
  localparam int unsigned RANDOM_SEED = 32'h56708644;

  logic          clk;
  logic          reset;
  logic          capture_start;
  logic          capture_stop;
  logic          readout_start;
  realtime_bus_t in_bus;
  realtime_bus_t diff_bus;
  logic          capturing;
  logic          readout_busy;
  readout_beat_t readout;

  // reference model state
  string                         test_name;
  channel_beat_t                 hist [`CHANNELS][$]; // every accepted input beat
  channel_beat_t                 cap [`CHANNELS][$];  // words the buffer should hold
  readout_beat_t                 exp_out [$];         // beats still due on the readout port
  int                            out_idx [`CHANNELS]; // next beat expected from the differentiator
  logic [`CHANNELS-1:0]          prev_in_valid;       // valids seen at the last edge
  channel_beat_t [`CHANNELS-1:0] pending_word;        // checked diff words of this cycle
  logic [`CHANNELS-1:0]          pending_valid;
  bit                            model_cap;
  int                            busy_cnt;  // cycles of readout_busy still to come
  int                            ro_total;  // beats in the current readout
  bit                            last_seen;

  differentiator_capture_top differentiator_capture_top_i (
    .clk           (clk),
    .reset         (reset),
    .capture_start (capture_start),
    .capture_stop  (capture_stop),
    .readout_start (readout_start),
    .in_bus        (in_bus),
    .diff_bus      (diff_bus),
    .capturing     (capturing),
    .readout_busy  (readout_busy),
    .readout       (readout)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_equal(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected)
      else stop_with_failure($sformatf("Error %s %s: expected %0h, actual %0h",
                                       test_name, what, expected, actual));
  endtask

  // floor of (cur - pred) / 2
  // integer division truncates toward zero so odd negatives step down by one
  function automatic sample_t halved_difference(input sample_t cur, input sample_t pred);
    int d;
    d = int'(cur) - int'(pred);
    if (d < 0 && (d % 2) != 0) begin
      return sample_t'(d / 2 - 1);
    end
    return sample_t'(d / 2);
  endfunction

  // one clock of stimulus driven just after the rising edge
  task automatic drive_cycle(input bit start, input bit stop, input bit ro_start,
                             input int valid_pct);
    @(posedge clk);
    #5;
    capture_start = start;
    capture_stop  = stop;
    readout_start = ro_start;
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      in_bus.valid[ch] = ($urandom_range(99) < valid_pct);
      for (int s = 0; s < `PARALLEL_SAMPLES; s++) begin
        in_bus.data[ch][s] = sample_t'($urandom()); // also random when not valid
      end
    end
  endtask

  task automatic stream_cycles(input int cycles, input int valid_pct);
    repeat (cycles) drive_cycle(1'b0, 1'b0, 1'b0, valid_pct);
  endtask

  // start a readout and keep streaming until the last beat shows up
  task automatic run_readout(input bit disturb, input int valid_pct);
    int n;
    n = 0;
    last_seen = 1'b0;
    drive_cycle(1'b0, 1'b0, 1'b1, valid_pct);
    while (!last_seen) begin
      n++;
      if (n > READOUT_CYCLES) begin
        stop_with_failure("readout never delivered its last beat");
      end
      drive_cycle(disturb && n == 2, 1'b0, disturb && n == 3, valid_pct); // pulses while busy
    end
  endtask

  // model update on the inputs the DUT samples at this edge
  always @(posedge clk) begin : model_update
    bit            busy_before;
    readout_beat_t beat;
    if (!reset) begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        if (in_bus.valid[ch]) hist[ch].push_back(in_bus.data[ch]);
      end
      prev_in_valid = in_bus.valid;
      busy_before = (busy_cnt > 0);
      if (readout_start && busy_cnt <= 1) begin // idle sequencer snapshots the counts
        for (int ch = 0; ch < `CHANNELS; ch++) begin
          beat = '0;
          beat.valid = 1'b1;
          beat.header = 1'b1;
          beat.word.header.channel = 8'(ch);
          beat.word.header.count = 16'(cap[ch].size());
          exp_out.push_back(beat);
          for (int i = 0; i < cap[ch].size(); i++) begin
            beat = '0;
            beat.valid = 1'b1;
            beat.word.samples = cap[ch][i]; // oldest first
            exp_out.push_back(beat);
          end
        end
        beat = exp_out.pop_back();
        beat.last = 1'b1;
        exp_out.push_back(beat);
        ro_total = exp_out.size();
        busy_cnt = ro_total + 1; // busy until the last beat has left
      end else if (busy_cnt > 0) begin
        busy_cnt--;
      end
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        if (model_cap && !busy_before && pending_valid[ch] && cap[ch].size() < `BUFFER_DEPTH)
          cap[ch].push_back(pending_word[ch]);
      end
      if (capture_start && !busy_before) begin
        model_cap = 1'b1;
        for (int ch = 0; ch < `CHANNELS; ch++) cap[ch].delete(); // counts back to zero
      end else if (capture_stop) begin
        model_cap = 1'b0;
      end
    end
  end

  // outputs are compared mid cycle where they are stable
  always @(negedge clk) begin : output_check
    channel_beat_t cur_beat;
    channel_beat_t want;
    sample_t       pred;
    int            idx;
    bit            want_valid;
    readout_beat_t want_beat;
    if (!reset) begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        pending_valid[ch] = 1'b0;
        if (diff_bus.valid[ch]) begin
          idx = out_idx[ch];
          assert (prev_in_valid[ch])
            else stop_with_failure($sformatf("channel %0d output without an input beat", ch));
          expect_equal($sformatf("diff ch%0d accepted beats", ch), idx + 4, hist[ch].size());
          cur_beat = hist[ch][idx];
          for (int s = 0; s < `PARALLEL_SAMPLES; s++) begin
            if (s == 0) pred = (idx == 0) ? sample_t'(0) : hist[ch][idx-1][`PARALLEL_SAMPLES-1];
            else pred = cur_beat[s-1];
            want[s] = halved_difference(cur_beat[s], pred);
          end
          expect_equal($sformatf("diff ch%0d beat %0d", ch, idx), want, diff_bus.data[ch]);
          pending_word[ch] = want;
          pending_valid[ch] = 1'b1;
          out_idx[ch]++;
        end
      end
      expect_equal("capturing", model_cap, capturing);
      expect_equal("readout busy", busy_cnt > 0, readout_busy);
      want_valid = (busy_cnt >= 1) && (busy_cnt <= ro_total); // first beat one cycle late
      expect_equal("readout valid", want_valid, readout.valid);
      if (want_valid) begin
        want_beat = exp_out.pop_front();
        expect_equal("readout beat", want_beat, readout);
        last_seen = readout.last;
      end else begin
        expect_equal("readout last", 1'b0, readout.last);
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) readout.last |-> readout.valid)
    else stop_with_failure("readout last flag raised on a beat that is not valid");
  assert property (@(posedge clk) disable iff (reset) readout.valid |-> readout_busy)
    else stop_with_failure("readout beat sent while the sequencer reports idle");

  initial begin : watchdog
    #(WATCHDOG_TIME);
    stop_with_failure("watchdog timeout, the run did not reach its end in time");
  end

  initial begin
    void'($urandom(RANDOM_SEED)); // seeds the generator once
    clk = 1'b0;
    reset = 1'b1;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    readout_start = 1'b0;
    in_bus = '0;
    test_name = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    #5 reset = 1'b0;

    test_name = "idle after reset"; // monitor expects every output low
    stream_cycles(IDLE_CYCLES, 0);

    test_name = "random valid gaps";
    stream_cycles(STREAM_CYCLES, 60);
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      assert (out_idx[ch] > 0)
        else stop_with_failure($sformatf("channel %0d produced no output", ch));
    end

    test_name = "capture window";
    drive_cycle(1'b1, 1'b0, 1'b0, 60);
    stream_cycles(WINDOW_CYCLES, 60);
    drive_cycle(1'b0, 1'b1, 1'b0, 60);
    stream_cycles(SHORT_CYCLES, 60); // words after stop are dropped
    run_readout(1'b0, 60);

    test_name = "capture saturation";
    drive_cycle(1'b1, 1'b0, 1'b0, 80);
    stream_cycles(SATURATE_CYCLES, 80);
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      assert (cap[ch].size() == `BUFFER_DEPTH)
        else stop_with_failure($sformatf("channel %0d never filled its region", ch));
    end
    run_readout(1'b0, 80);

    test_name = "pulses during readout";
    drive_cycle(1'b1, 1'b0, 1'b0, 50);
    stream_cycles(SHORT_CYCLES, 50);
    run_readout(1'b1, 70); // capture keeps running while busy blocks the writes
    drive_cycle(1'b0, 1'b1, 1'b0, 50);
    stream_cycles(SHORT_CYCLES, 0);
    run_readout(1'b0, 0);

    test_name = "restart clears counts";
    drive_cycle(1'b1, 1'b0, 1'b0, 0);
    drive_cycle(1'b0, 1'b1, 1'b0, 0);
    stream_cycles(SHORT_CYCLES, 0);
    run_readout(1'b0, 0);

    if (exp_out.size() == 0 && busy_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_with_failure("readout ended with expected beats still outstanding");
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
realtime_pkg.sv
realtime_differentiator.sv
sample_capture_buffer.sv
buffer_readout.sv
differentiator_capture_top.sv
tb_differentiator_capture.sv

// File: Makefile
# Verilator build for the differentiator capture path

TOP := tb_differentiator_capture

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
